//--- Makefile
# Verilator flow for the CSR NFA scanner
# every variable can be overridden on the command line

VERILATOR ?= verilator
TOP ?= csr_nfa_tb
FILELIST ?= all.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_TEXT ?= Simulation passed
LINT_FLAGS ?= --lint-only --timing
SIM_FLAGS ?= --binary --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# pass or fail comes from the log, not from the exit code of the binary
sim: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- all.f
+incdir+include
hdl/csr_nfa_pkg.sv
hdl/active_scan.sv
hdl/csr_fetch.sv
hdl/lane_match.sv
hdl/csr_nfa_top.sv
verification/tb_clock.sv
verification/csr_mem_model.sv
verification/csr_nfa_tb.sv

//--- hdl/active_scan.sv
//////////////////////////////
// stage 1: state bitmaps of both streams and the index walk
// takes one character pair per step, hands active states on
//////////////////////////////
`timescale 1ns/1ns
`include "csr_nfa_macros.svh"

module active_scan
(
	input logic clk,
	input logic reset,
	input csr_nfa_pkg::state_idx_t num_states,
	input logic char_valid,
	input csr_nfa_pkg::symbol_t char_a,
	input csr_nfa_pkg::symbol_t char_b,
	output logic char_ready,
	output csr_nfa_pkg::symbol_t scan_char_a,
	output csr_nfa_pkg::symbol_t scan_char_b,
	output logic visit_valid,
	output csr_nfa_pkg::state_idx_t visit_state,
	output logic visit_a,
	output logic visit_b,
	input logic visit_ready,
	input logic visit_done,
	input logic [`NFA_MAX_STATES-1:0] hit_a,
	input logic [`NFA_MAX_STATES-1:0] hit_b
);

	localparam int MAP_W = `NFA_MAX_STATES;
	localparam int IDX_W = $clog2(`NFA_MAX_STATES);

	csr_nfa_pkg::scan_state_e state_q;
	csr_nfa_pkg::state_idx_t idx;
	logic [MAP_W-1:0] current_a;
	logic [MAP_W-1:0] current_b;
	logic [MAP_W-1:0] next_a;
	logic [MAP_W-1:0] next_b;
	logic last_idx;
	logic idx_active;

	assign char_ready = (state_q == csr_nfa_pkg::scan_wait_char);
	assign last_idx = (idx == num_states - 1'b1);
	assign idx_active = current_a[idx[IDX_W-1:0]] | current_b[idx[IDX_W-1:0]];

	// character pair is held for the whole step
	always_ff @(posedge clk)
	begin
		if (char_valid && char_ready)
		begin
			scan_char_a <= char_a;
			scan_char_b <= char_b;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= csr_nfa_pkg::scan_wait_char;
			idx <= '0;
			visit_valid <= 1'b0;
			visit_state <= '0;
			visit_a <= 1'b0;
			visit_b <= 1'b0;
			// both streams start in state 0
			current_a <= MAP_W'(1);
			current_b <= MAP_W'(1);
			next_a <= '0;
			next_b <= '0;
		end
		else
		begin
			// match hits land here whatever the FSM is doing
			next_a <= next_a | hit_a;
			next_b <= next_b | hit_b;
			case (state_q)
				csr_nfa_pkg::scan_wait_char:
				begin
					if (char_valid)
					begin
						idx <= '0;
						state_q <= csr_nfa_pkg::scan_probe;
					end
				end
				csr_nfa_pkg::scan_probe:
				begin
					if (idx_active)
					begin
						visit_valid <= 1'b1;
						visit_state <= idx;
						visit_a <= current_a[idx[IDX_W-1:0]];
						visit_b <= current_b[idx[IDX_W-1:0]];
						state_q <= csr_nfa_pkg::scan_visit;
					end
					else if (last_idx)
						state_q <= csr_nfa_pkg::scan_swap;
					else
						idx <= idx + 1'b1;
				end
				csr_nfa_pkg::scan_visit:
				begin
					if (visit_ready)
						visit_valid <= 1'b0;
					// last hits of the visit arrive together with visit_done
					if (visit_done)
					begin
						if (last_idx)
							state_q <= csr_nfa_pkg::scan_swap;
						else
						begin
							idx <= idx + 1'b1;
							state_q <= csr_nfa_pkg::scan_probe;
						end
					end
				end
				default:
				begin
					current_a <= next_a;
					current_b <= next_b;
					next_a <= '0;
					next_b <= '0;
					state_q <= csr_nfa_pkg::scan_wait_char;
				end
			endcase
		end
	end

endmodule

//--- hdl/csr_fetch.sv
//////////////////////////////
// stage 2: row pointer and edge line reads from block memory
// emits one lane-masked line per cycle of read data
//////////////////////////////
`timescale 1ns/1ns
`include "csr_nfa_macros.svh"

module csr_fetch
(
	input logic clk,
	input logic reset,
	input csr_nfa_pkg::state_idx_t num_states,
	input logic visit_valid,
	input csr_nfa_pkg::state_idx_t visit_state,
	input logic visit_a,
	input logic visit_b,
	output logic visit_ready,
	output logic rd_en,
	output csr_nfa_pkg::line_addr_t rd_addr,
	input csr_nfa_pkg::mem_line_t rd_data,
	output logic item_valid,
	output csr_nfa_pkg::mem_line_t item_line,
	output csr_nfa_pkg::lane_mask_t item_mask,
	output logic item_a,
	output logic item_b,
	output logic item_last,
	output logic item_accepting
);

	// word address is the line address plus the lane
	localparam int WORD_ADDR_W = `NFA_ADDR_W + 2;

	csr_nfa_pkg::fetch_state_e state_q;
	csr_nfa_pkg::state_idx_t cur_k;
	logic cur_a;
	logic cur_b;
	logic crossed;
	logic [`NFA_WORD_W-1:0] ptr_lo;
	logic [WORD_ADDR_W-1:0] word_addr;
	logic [WORD_ADDR_W-1:0] remain;

	logic [1:0] ptr_lane;
	logic [1:0] ptr_lane_next;
	logic [`NFA_WORD_W-1:0] lo_word;
	logic [`NFA_WORD_W-1:0] hi_word;
	logic [`NFA_WORD_W-1:0] edge_count;
	logic ptr_done;
	logic acc_item;
	logic edge_item;
	logic [1:0] start_lane;
	logic [2:0] room;
	logic [2:0] take;
	logic line_last;
	csr_nfa_pkg::lane_mask_t mask;

	assign visit_ready = (state_q == csr_nfa_pkg::fetch_idle);
	assign ptr_lane = cur_k[1:0];
	assign ptr_lane_next = ptr_lane + 2'd1;

	// ptr[k] and ptr[k+1], the latter from the next line when k sits in lane 3
	assign lo_word = crossed ? ptr_lo : csr_nfa_pkg::lane_word(rd_data, ptr_lane);
	assign hi_word = crossed ? csr_nfa_pkg::lane_word(rd_data, 0)
		: csr_nfa_pkg::lane_word(rd_data, ptr_lane_next);
	assign ptr_done = crossed || (ptr_lane != 2'd3);
	assign edge_count = hi_word - lo_word;

	// lanes of this line that still belong to the state
	assign start_lane = word_addr[1:0];
	assign room = 3'd4 - {1'b0, start_lane};
	assign line_last = (remain <= WORD_ADDR_W'(room));
	assign take = line_last ? remain[2:0] : room;

	always_comb
	begin
		for (int l = 0; l < `NFA_LANES; l++)
			mask[l] = (l >= start_lane) && (l < start_lane + take);
	end

	always_comb
	begin
		rd_en = 1'b0;
		rd_addr = cur_k[`NFA_ADDR_W+1:2];
		case (state_q)
			csr_nfa_pkg::fetch_ptr_read:
				rd_en = 1'b1;
			csr_nfa_pkg::fetch_ptr_second:
			begin
				rd_en = 1'b1;
				rd_addr = cur_k[`NFA_ADDR_W+1:2] + 1'b1;
			end
			csr_nfa_pkg::fetch_edge_read:
			begin
				rd_en = 1'b1;
				rd_addr = word_addr[WORD_ADDR_W-1:2];
			end
			default:
				rd_en = 1'b0;
		endcase
	end

	// items are taken straight off the read data
	assign acc_item = (state_q == csr_nfa_pkg::fetch_ptr_wait) && ptr_done && (edge_count == '0);
	assign edge_item = (state_q == csr_nfa_pkg::fetch_edge_wait);
	assign item_valid = acc_item || edge_item;
	assign item_line = rd_data;
	assign item_mask = edge_item ? mask : '0;
	assign item_a = cur_a;
	assign item_b = cur_b;
	assign item_last = acc_item || (edge_item && line_last);
	assign item_accepting = acc_item;

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			state_q <= csr_nfa_pkg::fetch_idle;
			crossed <= 1'b0;
		end
		else
		begin
			case (state_q)
				csr_nfa_pkg::fetch_idle:
				begin
					if (visit_valid)
					begin
						cur_k <= visit_state;
						cur_a <= visit_a;
						cur_b <= visit_b;
						crossed <= 1'b0;
						state_q <= csr_nfa_pkg::fetch_ptr_read;
					end
				end
				csr_nfa_pkg::fetch_ptr_read:
					state_q <= csr_nfa_pkg::fetch_ptr_wait;
				csr_nfa_pkg::fetch_ptr_wait:
				begin
					if (!ptr_done)
					begin
						ptr_lo <= csr_nfa_pkg::lane_word(rd_data, 3);
						crossed <= 1'b1;
						state_q <= csr_nfa_pkg::fetch_ptr_second;
					end
					else if (edge_count == '0)
						state_q <= csr_nfa_pkg::fetch_idle;
					else
					begin
						// edges start right after the num_states+1 pointers
						word_addr <= WORD_ADDR_W'(num_states) + WORD_ADDR_W'(lo_word) + 1'b1;
						remain <= edge_count[WORD_ADDR_W-1:0];
						state_q <= csr_nfa_pkg::fetch_edge_read;
					end
				end
				csr_nfa_pkg::fetch_ptr_second:
					state_q <= csr_nfa_pkg::fetch_ptr_wait;
				csr_nfa_pkg::fetch_edge_read:
					state_q <= csr_nfa_pkg::fetch_edge_wait;
				default:
				begin
					word_addr <= word_addr + WORD_ADDR_W'(take);
					remain <= remain - WORD_ADDR_W'(take);
					if (line_last)
						state_q <= csr_nfa_pkg::fetch_idle;
					else
						state_q <= csr_nfa_pkg::fetch_edge_read;
				end
			endcase
		end
	end

endmodule

//--- hdl/csr_nfa_pkg.sv
//////////////////////////////
// types and FSM encodings of the CSR NFA scanner
// referenced by scoped name from every stage
//////////////////////////////
`include "csr_nfa_macros.svh"

package csr_nfa_pkg;

	typedef logic [`NFA_SYM_W-1:0] symbol_t;
	typedef logic [`NFA_STATE_W-1:0] state_idx_t;
	typedef logic [`NFA_ADDR_W-1:0] line_addr_t;
	// lane 0 in the top word, lane 3 in the bottom word
	typedef logic [`NFA_LINE_W-1:0] mem_line_t;
	typedef logic [`NFA_LANES-1:0] lane_mask_t;

	typedef enum logic [1:0] {scan_wait_char, scan_probe, scan_visit, scan_swap} scan_state_e;

	typedef enum logic [2:0] {fetch_idle, fetch_ptr_read, fetch_ptr_wait, fetch_ptr_second,
		fetch_edge_read, fetch_edge_wait} fetch_state_e;

	// one 32-bit word of a line, by lane number
	function automatic logic [`NFA_WORD_W-1:0] lane_word(input mem_line_t line,
		input int unsigned lane);
		return line[`NFA_LINE_W-1-lane*`NFA_WORD_W -: `NFA_WORD_W];
	endfunction

endpackage

//--- hdl/csr_nfa_top.sv
//////////////////////////////
// top level of the two-stream CSR NFA scanner
// scan, fetch and match stages on one block memory port
//////////////////////////////
`timescale 1ns/1ns
`include "csr_nfa_macros.svh"

module csr_nfa_top
(
	input logic clk,
	input logic reset,
	input csr_nfa_pkg::state_idx_t num_states,
	output logic char_ready,
	input logic char_valid,
	input csr_nfa_pkg::symbol_t char_a,
	input csr_nfa_pkg::symbol_t char_b,
	output logic rd_en,
	output csr_nfa_pkg::line_addr_t rd_addr,
	input csr_nfa_pkg::mem_line_t rd_data,
	output logic accept_a,
	output logic accept_b
);

	csr_nfa_pkg::symbol_t scan_char_a;
	csr_nfa_pkg::symbol_t scan_char_b;
	logic visit_valid;
	csr_nfa_pkg::state_idx_t visit_state;
	logic visit_a;
	logic visit_b;
	logic visit_ready;
	logic visit_done;
	logic [`NFA_MAX_STATES-1:0] hit_a;
	logic [`NFA_MAX_STATES-1:0] hit_b;
	logic item_valid;
	csr_nfa_pkg::mem_line_t item_line;
	csr_nfa_pkg::lane_mask_t item_mask;
	logic item_a;
	logic item_b;
	logic item_last;
	logic item_accepting;

	active_scan u_scan (.clk(clk), .reset(reset), .num_states(num_states),
		.char_valid(char_valid), .char_a(char_a), .char_b(char_b), .char_ready(char_ready),
		.scan_char_a(scan_char_a), .scan_char_b(scan_char_b),
		.visit_valid(visit_valid), .visit_state(visit_state), .visit_a(visit_a),
		.visit_b(visit_b), .visit_ready(visit_ready), .visit_done(visit_done),
		.hit_a(hit_a), .hit_b(hit_b));

	csr_fetch u_fetch (.clk(clk), .reset(reset), .num_states(num_states),
		.visit_valid(visit_valid), .visit_state(visit_state), .visit_a(visit_a),
		.visit_b(visit_b), .visit_ready(visit_ready),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.item_valid(item_valid), .item_line(item_line), .item_mask(item_mask),
		.item_a(item_a), .item_b(item_b), .item_last(item_last),
		.item_accepting(item_accepting));

	// compare runs against the pair registered for this step
	lane_match u_match (.clk(clk), .reset(reset), .char_a(scan_char_a), .char_b(scan_char_b),
		.item_valid(item_valid), .item_line(item_line), .item_mask(item_mask),
		.item_a(item_a), .item_b(item_b), .item_last(item_last),
		.item_accepting(item_accepting), .hit_a(hit_a), .hit_b(hit_b),
		.accept_a(accept_a), .accept_b(accept_b), .visit_done(visit_done));

endmodule

//--- hdl/lane_match.sv
//////////////////////////////
// stage 3: four-lane symbol compare for both streams
// returns target hits, accept pulses and the end of a visit
//////////////////////////////
`timescale 1ns/1ns
`include "csr_nfa_macros.svh"

module lane_match
(
	input logic clk,
	input logic reset,
	input csr_nfa_pkg::symbol_t char_a,
	input csr_nfa_pkg::symbol_t char_b,
	input logic item_valid,
	input csr_nfa_pkg::mem_line_t item_line,
	input csr_nfa_pkg::lane_mask_t item_mask,
	input logic item_a,
	input logic item_b,
	input logic item_last,
	input logic item_accepting,
	output logic [`NFA_MAX_STATES-1:0] hit_a,
	output logic [`NFA_MAX_STATES-1:0] hit_b,
	output logic accept_a,
	output logic accept_b,
	output logic visit_done
);

	localparam int IDX_W = $clog2(`NFA_MAX_STATES);

	logic [`NFA_MAX_STATES-1:0] hit_a_d;
	logic [`NFA_MAX_STATES-1:0] hit_b_d;

	always_comb
	begin
		logic [`NFA_WORD_W-1:0] word;
		csr_nfa_pkg::symbol_t sym;
		csr_nfa_pkg::state_idx_t tgt;

		hit_a_d = '0;
		hit_b_d = '0;
		for (int l = 0; l < `NFA_LANES; l++)
		begin
			word = csr_nfa_pkg::lane_word(item_line, l);
			sym = word[`NFA_WORD_W-1 -: `NFA_SYM_W];
			tgt = word[`NFA_STATE_W-1:0];
			// targets past the bitmap are dropped
			if (item_valid && item_mask[l] && (tgt < `NFA_MAX_STATES))
			begin
				if (item_a && (sym == char_a))
					hit_a_d[tgt[IDX_W-1:0]] = 1'b1;
				if (item_b && (sym == char_b))
					hit_b_d[tgt[IDX_W-1:0]] = 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			hit_a <= '0;
			hit_b <= '0;
			accept_a <= 1'b0;
			accept_b <= 1'b0;
			visit_done <= 1'b0;
		end
		else
		begin
			hit_a <= hit_a_d;
			hit_b <= hit_b_d;
			// a state with no edges accepts in each stream it is active in
			accept_a <= item_valid && item_accepting && item_a;
			accept_b <= item_valid && item_accepting && item_b;
			visit_done <= item_valid && item_last;
		end
	end

endmodule

//--- include/csr_nfa_macros.svh
//////////////////////////////
// widths and counts shared by the CSR NFA scanner
// include wherever a width or count is needed
//////////////////////////////
`ifndef CSR_NFA_MACROS_SVH
`define CSR_NFA_MACROS_SVH

// edge words per memory line, fixed
`define NFA_LANES 4
`define NFA_WORD_W 32
`define NFA_LINE_W 128

// fields of an edge word
`define NFA_SYM_W 8
`define NFA_STATE_W 24

// bitmap length, may be changed
`define NFA_MAX_STATES 64

`define NFA_ADDR_W 16

`endif

//--- verification/csr_mem_model.sv
//////////////////////////////
// 128-bit block memory model, one cycle of read latency
// written line by line by the testbench before a test
//////////////////////////////
`timescale 1ns/1ns
`include "csr_nfa_macros.svh"

module csr_mem_model
#(
	parameter int LINES = 64
)
(
	input logic clk,
	input logic wr_en,
	input csr_nfa_pkg::line_addr_t wr_addr,
	input csr_nfa_pkg::mem_line_t wr_data,
	input logic rd_en,
	input csr_nfa_pkg::line_addr_t rd_addr,
	output csr_nfa_pkg::mem_line_t rd_data
);

	localparam int IDX_W = $clog2(LINES);

	csr_nfa_pkg::mem_line_t mem [0:LINES-1];

	initial
		rd_data = '0;

	always @(posedge clk)
	begin
		if (wr_en)
			mem[wr_addr[IDX_W-1:0]] <= wr_data;
		// data shows up one cycle after the read enable
		if (rd_en)
			rd_data <= mem[rd_addr[IDX_W-1:0]];
	end

endmodule

//--- verification/csr_nfa_tb.sv
//////////////////////////////
// testbench for the CSR NFA scanner
// builds automaton images, runs directed tests against a model
//////////////////////////////
`timescale 1ns/1ns
`include "csr_nfa_macros.svh"

module csr_nfa_tb;

	localparam int PERIOD = 8;
	localparam int MAP_W = `NFA_MAX_STATES;
	localparam int LINES = 64;
	localparam int WORDS = LINES * `NFA_LANES;
	localparam int MAX_EDGES = 64;
	localparam int RAND_STEPS = 40;
	localparam int MAX_N = 12;
	// steps of tests 2 to 6
	localparam int TOTAL_STEPS = 3 + 8 + 6 * 8 + 2 * RAND_STEPS;
	localparam int LIMIT_CYCLES = TOTAL_STEPS * MAX_N * 12 + 4000;

	logic clk;
	logic por_reset;
	logic soft_reset;
	logic reset;
	csr_nfa_pkg::state_idx_t num_states;
	logic char_ready;
	logic char_valid;
	csr_nfa_pkg::symbol_t char_a;
	csr_nfa_pkg::symbol_t char_b;
	logic rd_en;
	csr_nfa_pkg::line_addr_t rd_addr;
	csr_nfa_pkg::mem_line_t rd_data;
	logic accept_a;
	logic accept_b;
	logic wr_en;
	csr_nfa_pkg::line_addr_t wr_addr;
	csr_nfa_pkg::mem_line_t wr_data;

	// automaton under test, kept as an edge list sorted by source
	int n_states;
	int n_edges;
	int e_src [MAX_EDGES];
	csr_nfa_pkg::symbol_t e_sym [MAX_EDGES];
	int e_tgt [MAX_EDGES];
	logic [31:0] image [WORDS];
	logic [MAP_W-1:0] model_a;
	logic [MAP_W-1:0] model_b;

	int total_a;
	int total_b;
	int errors;
	int checks;
	integer seed;
	csr_nfa_pkg::symbol_t rec_a [RAND_STEPS];
	csr_nfa_pkg::symbol_t rec_b [RAND_STEPS];

	assign reset = por_reset || soft_reset;

	tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(4)) clock_gen (.clk(clk), .reset(por_reset));

	csr_mem_model #(.LINES(LINES)) mem_model (.clk(clk), .wr_en(wr_en), .wr_addr(wr_addr),
		.wr_data(wr_data), .rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data));

	csr_nfa_top UUT (.clk(clk), .reset(reset), .num_states(num_states),
		.char_ready(char_ready), .char_valid(char_valid), .char_a(char_a), .char_b(char_b),
		.rd_en(rd_en), .rd_addr(rd_addr), .rd_data(rd_data),
		.accept_a(accept_a), .accept_b(accept_b));

	// running pulse totals, a step reads the difference
	always @(negedge clk)
	begin
		if (por_reset)
		begin
			total_a <= 0;
			total_b <= 0;
		end
		else
		begin
			if (accept_a)
				total_a <= total_a + 1;
			if (accept_b)
				total_b <= total_b + 1;
		end
	end

	task automatic check_bit(input string name, input logic exp, input logic act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Error %s: expected %0b, actual %0b", name, exp, act);
		end
	endtask

	task automatic check_count(input string name, input csr_nfa_pkg::state_idx_t exp,
		input csr_nfa_pkg::state_idx_t act);
		checks++;
		if (act !== exp)
		begin
			errors++;
			$display("Error %s: expected %0d, actual %0d", name, exp, act);
		end
	endtask

	task automatic new_image(input int n);
		n_states = n;
		n_edges = 0;
	endtask

	task automatic add_edge(input int src, input csr_nfa_pkg::symbol_t sym, input int tgt);
		e_src[n_edges] = src;
		e_sym[n_edges] = sym;
		e_tgt[n_edges] = tgt;
		n_edges++;
	endtask

	// row pointers first, then the edge words, four words per line
	task automatic load_image;
		int ptr;
		for (int w = 0; w < WORDS; w++)
			image[w] = '0;
		for (int k = 0; k <= n_states; k++)
		begin
			ptr = 0;
			for (int e = 0; e < n_edges; e++)
				if (e_src[e] < k)
					ptr++;
			image[k] = 32'(ptr);
		end
		for (int e = 0; e < n_edges; e++)
			image[n_states + 1 + e] = {e_sym[e], 24'(e_tgt[e])};
		num_states = csr_nfa_pkg::state_idx_t'(n_states);
		for (int l = 0; l < LINES; l++)
		begin
			@(negedge clk);
			wr_en = 1'b1;
			wr_addr = csr_nfa_pkg::line_addr_t'(l);
			wr_data = {image[4*l], image[4*l+1], image[4*l+2], image[4*l+3]};
		end
		@(negedge clk);
		wr_en = 1'b0;
	endtask

	task automatic restart_dut;
		@(negedge clk);
		soft_reset = 1'b1;
		repeat (4) @(negedge clk);
		soft_reset = 1'b0;
		model_a = MAP_W'(1);
		model_b = MAP_W'(1);
	endtask

	// one character step of the reference automaton
	task automatic model_step(input csr_nfa_pkg::symbol_t ca, input csr_nfa_pkg::symbol_t cb,
		output csr_nfa_pkg::state_idx_t exp_a, output csr_nfa_pkg::state_idx_t exp_b);
		logic [MAP_W-1:0] nxt_a;
		logic [MAP_W-1:0] nxt_b;
		logic has_edges;
		nxt_a = '0;
		nxt_b = '0;
		exp_a = '0;
		exp_b = '0;
		for (int i = 0; i < n_states; i++)
		begin
			if (model_a[i] || model_b[i])
			begin
				has_edges = 1'b0;
				for (int e = 0; e < n_edges; e++)
				begin
					if (e_src[e] == i)
					begin
						has_edges = 1'b1;
						if (model_a[i] && e_sym[e] == ca)
							nxt_a[e_tgt[e]] = 1'b1;
						if (model_b[i] && e_sym[e] == cb)
							nxt_b[e_tgt[e]] = 1'b1;
					end
				end
				if (!has_edges && model_a[i])
					exp_a = exp_a + 1'b1;
				if (!has_edges && model_b[i])
					exp_b = exp_b + 1'b1;
			end
		end
		model_a = nxt_a;
		model_b = nxt_b;
	endtask

	// idle gap, handshake, then wait for char_ready to come back
	task automatic drive_step(input csr_nfa_pkg::symbol_t ca, input csr_nfa_pkg::symbol_t cb,
		input int gap, output csr_nfa_pkg::state_idx_t got_a,
		output csr_nfa_pkg::state_idx_t got_b);
		int start_a;
		int start_b;
		@(negedge clk);
		while (!char_ready)
			@(negedge clk);
		repeat (gap)
		begin
			@(negedge clk);
			check_bit("idle char_ready", 1'b1, char_ready);
		end
		start_a = total_a;
		start_b = total_b;
		char_valid = 1'b1;
		char_a = ca;
		char_b = cb;
		@(negedge clk);
		char_valid = 1'b0;
		// the DUT must work from its own copy of the pair
		char_a = ~ca;
		char_b = ~cb;
		while (!char_ready)
			@(negedge clk);
		got_a = csr_nfa_pkg::state_idx_t'(total_a - start_a);
		got_b = csr_nfa_pkg::state_idx_t'(total_b - start_b);
	endtask

	task automatic run_step(input string name, input csr_nfa_pkg::symbol_t ca,
		input csr_nfa_pkg::symbol_t cb, input int gap,
		output csr_nfa_pkg::state_idx_t got_a, output csr_nfa_pkg::state_idx_t got_b);
		csr_nfa_pkg::state_idx_t exp_a;
		csr_nfa_pkg::state_idx_t exp_b;
		drive_step(ca, cb, gap, got_a, got_b);
		model_step(ca, cb, exp_a, exp_b);
		check_count({name, " stream a"}, exp_a, got_a);
		check_count({name, " stream b"}, exp_b, got_b);
	endtask

	// 12 states, state 0 loops on every symbol so the scan never dies
	task automatic build_branching;
		new_image(12);
		add_edge(0, "a", 0);
		add_edge(0, "b", 0);
		add_edge(0, "c", 0);
		add_edge(0, "d", 0);
		add_edge(0, "a", 1);
		add_edge(0, "b", 4);
		add_edge(1, "b", 2);
		add_edge(1, "c", 5);
		add_edge(2, "c", 3);
		add_edge(4, "a", 6);
		add_edge(4, "d", 7);
		add_edge(4, "b", 4);
		add_edge(5, "d", 8);
		add_edge(7, "a", 9);
		add_edge(7, "c", 10);
		add_edge(7, "d", 7);
		add_edge(9, "b", 11);
		load_image();
	endtask

	task automatic test_reset_values;
		repeat (4)
		begin
			@(negedge clk);
			check_bit("reset char_ready", 1'b1, char_ready);
			check_bit("reset rd_en", 1'b0, rd_en);
			check_bit("reset accept_a", 1'b0, accept_a);
			check_bit("reset accept_b", 1'b0, accept_b);
		end
	endtask

	task automatic test_literal_ab;
		csr_nfa_pkg::state_idx_t got_a;
		csr_nfa_pkg::state_idx_t got_b;
		new_image(3);
		add_edge(0, "a", 1);
		add_edge(1, "b", 2);
		load_image();
		restart_dut();
		run_step("ab step 1", "a", "b", 0, got_a, got_b);
		run_step("ab step 2", "b", "a", 0, got_a, got_b);
		run_step("ab step 3", "c", "c", 0, got_a, got_b);
		check_count("ab accept a", 1, got_a);
		check_count("ab accept b", 0, got_b);
	endtask

	task automatic test_independent;
		csr_nfa_pkg::symbol_t seq_a [8] = '{"a", "b", "c", "d", "a", "b", "b", "c"};
		csr_nfa_pkg::symbol_t seq_b [8] = '{"b", "d", "a", "c", "b", "a", "a", "d"};
		csr_nfa_pkg::state_idx_t got_a;
		csr_nfa_pkg::state_idx_t got_b;
		build_branching();
		restart_dut();
		for (int s = 0; s < 8; s++)
			run_step("independent", seq_a[s], seq_b[s], 0, got_a, got_b);
	endtask

	// pointer of state 3 in lane 3, its six edges start in lane 1
	// each target is a different number of z steps away from accepting state 7
	task automatic test_line_cross;
		csr_nfa_pkg::symbol_t syms [6] = '{"p", "q", "r", "s", "t", "u"};
		int hops [6] = '{3, 2, 1, 0, 5, 4};
		csr_nfa_pkg::state_idx_t got_a;
		csr_nfa_pkg::state_idx_t got_b;
		// state 8 has no edges, it only moves the edge words by one lane
		new_image(9);
		add_edge(0, "x", 3);
		add_edge(1, "z", 2);
		add_edge(2, "z", 4);
		add_edge(3, "p", 4);
		add_edge(3, "q", 5);
		add_edge(3, "r", 6);
		add_edge(3, "s", 7);
		add_edge(3, "t", 1);
		add_edge(3, "u", 2);
		add_edge(4, "z", 5);
		add_edge(5, "z", 6);
		add_edge(6, "z", 7);
		load_image();
		for (int i = 0; i < 6; i++)
		begin
			restart_dut();
			run_step("cross enter", "x", "x", 0, got_a, got_b);
			run_step("cross edge", syms[i], syms[5-i], 0, got_a, got_b);
			for (int z = 0; z < 6; z++)
			begin
				run_step("cross chain", "z", "z", 0, got_a, got_b);
				check_count("cross target a", (z == hops[i]) ? 1 : 0, got_a);
				check_count("cross target b", (z == hops[5-i]) ? 1 : 0, got_b);
			end
		end
	endtask

	task automatic test_random_chars;
		csr_nfa_pkg::state_idx_t got_a;
		csr_nfa_pkg::state_idx_t got_b;
		build_branching();
		restart_dut();
		for (int s = 0; s < RAND_STEPS; s++)
		begin
			rec_a[s] = csr_nfa_pkg::symbol_t'(8'h61 + ($random(seed) & 3));
			rec_b[s] = csr_nfa_pkg::symbol_t'(8'h61 + ($random(seed) & 3));
			run_step("random", rec_a[s], rec_b[s], 0, got_a, got_b);
		end
	endtask

	// same pairs as the random test, with idle gaps in between
	task automatic test_backpressure;
		csr_nfa_pkg::state_idx_t got_a;
		csr_nfa_pkg::state_idx_t got_b;
		int gap;
		restart_dut();
		for (int s = 0; s < RAND_STEPS; s++)
		begin
			gap = $unsigned($random(seed)) % 6;
			run_step("backpressure", rec_a[s], rec_b[s], gap, got_a, got_b);
		end
	endtask

	initial
	begin
		seed = 32'h339a_4f04;
		soft_reset = 1'b0;
		num_states = csr_nfa_pkg::state_idx_t'(1);
		char_valid = 1'b0;
		char_a = '0;
		char_b = '0;
		wr_en = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		errors = 0;
		checks = 0;
		model_a = MAP_W'(1);
		model_b = MAP_W'(1);
		while (por_reset !== 1'b0)
			@(negedge clk);
		test_reset_values();
		test_literal_ab();
		test_independent();
		test_line_cross();
		test_random_chars();
		test_backpressure();
		$display("checks run: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

	// bound on the whole run, from the step count and the largest automaton
	initial
	begin
		#(LIMIT_CYCLES * PERIOD);
		$display("watchdog: the tests did not finish within %0d cycles", LIMIT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- verification/tb_clock.sv
//////////////////////////////
// testbench clock and power-on reset
// period and reset length are parameters
//////////////////////////////
`timescale 1ns/1ns

module tb_clock
#(
	parameter int PERIOD = 8,
	parameter int RESET_CYCLES = 4
)
(
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// released on a falling edge, like every other testbench input
	initial
	begin
		reset = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
	end

endmodule
